// ==== cpuPkg.sv ====
// Covers only the RV32I subset below with word accesses; no CSR, shift or byte encodings exist.
package cpuPkg;

  typedef logic [31:0] word_t;   // Data or address word.
  typedef logic [4:0]  regIdx_t; // Register index, x0 to x31.
  typedef logic [3:0]  aluOp_t;
  typedef logic [1:0]  wbSel_t;  // Source of the register write-back.

  localparam aluOp_t ALU_ADD   = 4'd0;
  localparam aluOp_t ALU_SUB   = 4'd1; // Also the compare for BEQ and BNE.
  localparam aluOp_t ALU_AND   = 4'd2;
  localparam aluOp_t ALU_OR    = 4'd3;
  localparam aluOp_t ALU_XOR   = 4'd4;
  localparam aluOp_t ALU_SLT   = 4'd5; // Signed compare.
  localparam aluOp_t ALU_PASSB = 4'd6; // Operand B straight through, used by LUI.

  localparam logic [6:0] OP_RTYPE  = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADDSUB = 3'b000;
  localparam logic [2:0] F3_SLT    = 3'b010;
  localparam logic [2:0] F3_XOR    = 3'b100;
  localparam logic [2:0] F3_OR     = 3'b110;
  localparam logic [2:0] F3_AND    = 3'b111;
  localparam logic [2:0] F3_WORD   = 3'b010; // LW and SW width.
  localparam logic [2:0] F3_BEQ    = 3'b000;
  localparam logic [2:0] F3_BNE    = 3'b001;

  localparam word_t EBREAK_WORD = 32'h0010_0073;

  localparam wbSel_t WB_ALU = 2'd0;
  localparam wbSel_t WB_MEM = 2'd1;
  localparam wbSel_t WB_PC4 = 2'd2; // Link address for JAL.

  localparam word_t RESET_PC = 32'h0000_0000;

  typedef struct packed {
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
    word_t   imm;      // Sign-extended immediate of the current format.
    aluOp_t  aluOp;
    logic    aluSrc;   // Immediate replaces rs2 as operand B.
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    wbSel_t  wbSel;
    logic    isBranch;
    logic    branchNe; // Branch on not equal instead of equal.
    logic    isJal;
    logic    isHalt;
  } ctrl_t;

  typedef enum logic [2:0] {
    IDLE,   // Waiting for enable.
    FETCH,  // Instruction read on the RAM port.
    DECODE, // Operands settle.
    DATA,   // LW or SW transfer.
    COMMIT, // Register write and PC update.
    HALT    // Stopped by EBREAK until reset.
  } reqState_t;

endpackage

// ==== controlDecoder.sv ====
// Purely combinational; anything outside the supported subset decodes to a no-op with no writes.
module controlDecoder (
  input  cpuPkg::word_t instruction,
  output cpuPkg::ctrl_t ctrl
);
  import cpuPkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       altFunct;
  word_t      immI;
  word_t      immS;
  word_t      immB;
  word_t      immU;
  word_t      immJ;

  assign opcode   = instruction[6:0];
  assign funct3   = instruction[14:12];
  assign altFunct = instruction[30]; // Bit 5 of funct7 selects SUB.

  assign immI = {{20{instruction[31]}}, instruction[31:20]};
  assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                 instruction[30:25], instruction[11:8], 1'b0};
  assign immU = {instruction[31:12], 12'b0};
  assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                 instruction[20], instruction[30:21], 1'b0};

  always_comb begin
    ctrl          = '0;
    ctrl.rs1      = instruction[19:15];
    ctrl.rs2      = instruction[24:20];
    ctrl.rd       = instruction[11:7];
    ctrl.imm      = immI;
    ctrl.aluOp    = ALU_ADD;
    ctrl.wbSel    = WB_ALU;
    case (opcode)
      OP_RTYPE: begin
        ctrl.regWrite = 1'b1;
        case (funct3)
          F3_ADDSUB: ctrl.aluOp = altFunct ? ALU_SUB : ALU_ADD;
          F3_SLT:    ctrl.aluOp = ALU_SLT;
          F3_XOR:    ctrl.aluOp = ALU_XOR;
          F3_OR:     ctrl.aluOp = ALU_OR;
          F3_AND:    ctrl.aluOp = ALU_AND;
          default:   ctrl.regWrite = 1'b0; // Shifts and SLTU are not built.
        endcase
      end
      OP_IMM: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = (funct3 == F3_ADDSUB); // Only ADDI.
      end
      OP_LUI: begin
        ctrl.imm      = immU;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = ALU_PASSB;
        ctrl.regWrite = 1'b1;
      end
      OP_LOAD: begin
        if (funct3 == F3_WORD) begin
          ctrl.aluSrc   = 1'b1;
          ctrl.memRead  = 1'b1;
          ctrl.regWrite = 1'b1;
          ctrl.wbSel    = WB_MEM;
        end
      end
      OP_STORE: begin
        ctrl.imm = immS;
        if (funct3 == F3_WORD) begin
          ctrl.aluSrc   = 1'b1;
          ctrl.memWrite = 1'b1;
        end
      end
      OP_BRANCH: begin
        ctrl.imm      = immB;
        ctrl.aluOp    = ALU_SUB;                // Zero flag tells equality.
        ctrl.isBranch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        ctrl.branchNe = (funct3 == F3_BNE);
      end
      OP_JAL: begin
        ctrl.imm      = immJ;
        ctrl.isJal    = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = WB_PC4;
      end
      OP_SYSTEM: begin
        ctrl.isHalt = (instruction == EBREAK_WORD); // ECALL and CSRs fall through.
      end
      default: begin
        ctrl.imm = immI;
      end
    endcase
  end

endmodule

// ==== aluUnit.sv ====
// Combinational ALU without shifts; SLT is signed and flags describe the result only.
module aluUnit (
  input  cpuPkg::aluOp_t aluOp,
  input  cpuPkg::word_t  inputA,
  input  cpuPkg::word_t  inputB,
  output cpuPkg::word_t  result,
  output logic           zero,
  output logic           negative
);
  import cpuPkg::*;

  logic lessThan;

  assign lessThan = $signed(inputA) < $signed(inputB);

  always_comb begin
    case (aluOp)
      ALU_ADD: begin
        result = inputA + inputB;
      end
      ALU_SUB: begin
        result = inputA - inputB;
      end
      ALU_AND: begin
        result = inputA & inputB;
      end
      ALU_OR: begin
        result = inputA | inputB;
      end
      ALU_XOR: begin
        result = inputA ^ inputB;
      end
      ALU_SLT: begin
        result = {31'b0, lessThan}; // One or zero.
      end
      ALU_PASSB: begin
        result = inputB;            // LUI immediate already shifted.
      end
      default: begin
        result = '0;
      end
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[31];

endmodule

// ==== registerFile.sv ====
// Two asynchronous reads and one clocked write; writes to x0 are dropped so it always reads zero.
module registerFile (
  input  logic            clk,
  input  logic            reset,
  input  logic            writeEn,
  input  cpuPkg::regIdx_t readIdx1,
  input  cpuPkg::regIdx_t readIdx2,
  input  cpuPkg::regIdx_t writeIdx,
  input  cpuPkg::word_t   writeData,
  output cpuPkg::word_t   readData1,
  output cpuPkg::word_t   readData2
);
  import cpuPkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeIdx != '0)) begin
      regs[writeIdx] <= writeData; // Lands at the end of COMMIT.
    end
  end

  // Reads see the old value during the commit cycle.
  assign readData1 = regs[readIdx1];
  assign readData2 = regs[readIdx2];

endmodule

// ==== programCounter.sv ====
// PC changes only on the commit pulse; targets are PC-relative and misaligned targets are not trapped.
module programCounter (
  input  logic          clk,
  input  logic          reset,
  input  logic          commit,
  input  cpuPkg::ctrl_t ctrl,
  input  logic          zero,
  output cpuPkg::word_t pc,
  output cpuPkg::word_t pcPlus4
);
  import cpuPkg::*;

  logic  branchTaken;
  logic  takeTarget;
  word_t target;
  word_t nextPc;

  assign pcPlus4     = pc + 32'd4;
  assign target      = pc + ctrl.imm;                 // JAL and branch share the adder.
  assign branchTaken = ctrl.isBranch && (zero ^ ctrl.branchNe);
  assign takeTarget  = ctrl.isJal || branchTaken;

  always_comb begin
    if (takeTarget) begin
      nextPc = target;
    end else if (ctrl.isHalt) begin
      nextPc = pc;                                    // Stays on the EBREAK.
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (commit) begin
      pc <= nextPc;
    end
  end

endmodule

// ==== memRequest.sv ====
// One RAM port for fetch and data; a request is held until busy is low and only words move.
module memRequest (
  input  logic          clk,
  input  logic          reset,
  input  logic          enable,
  input  logic          busy,
  input  logic          halt,
  input  cpuPkg::word_t pc,
  input  cpuPkg::word_t dataAddr,
  input  cpuPkg::word_t storeData,
  input  cpuPkg::word_t ramLoad,
  input  logic          memRead,
  input  logic          memWrite,
  output cpuPkg::word_t ramAddr,
  output cpuPkg::word_t ramStore,
  output logic          ren,
  output logic          wen,
  output logic          halted,
  output cpuPkg::word_t instruction,
  output cpuPkg::word_t loadData,
  output logic          commit
);
  import cpuPkg::*;

  reqState_t state;
  reqState_t nextState;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (enable) begin
          nextState = FETCH;
        end
      end
      FETCH: begin
        if (!busy) begin
          nextState = DECODE;
        end
      end
      DECODE: begin
        nextState = (memRead || memWrite) ? DATA : COMMIT;
      end
      DATA: begin
        if (!busy) begin
          nextState = COMMIT;
        end
      end
      COMMIT: begin
        if (halt) begin
          nextState = HALT;
        end else begin
          nextState = enable ? FETCH : IDLE; // Pause between instructions.
        end
      end
      default: begin
        nextState = HALT;                    // Left only by reset.
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if ((state == FETCH) && !busy) begin
      instruction <= ramLoad;                // Read data is valid in the completing cycle.
    end
    if ((state == DATA) && !busy && memRead) begin
      loadData <= ramLoad;
    end
  end

  // Port outputs depend only on state and operands that hold still during a transfer.
  assign ren      = (state == FETCH) || ((state == DATA) && memRead);
  assign wen      = (state == DATA) && memWrite;
  assign ramAddr  = (state == DATA) ? dataAddr : pc;
  assign ramStore = storeData;
  assign commit   = (state == COMMIT);
  assign halted   = (state == HALT);

endmodule

// ==== cpuTop.sv ====
// Multi-cycle core with one instruction in flight on a single RAM port; enable pauses between instructions.
module cpuTop (
  input  logic          clk,
  input  logic          reset,
  input  logic          enable,
  input  cpuPkg::word_t ramLoad,
  input  logic          busy,
  output cpuPkg::word_t ramAddr,
  output cpuPkg::word_t ramStore,
  output logic          ren,
  output logic          wen,
  output logic          halted
);
  import cpuPkg::*;

  ctrl_t ctrl;
  word_t instruction;
  word_t loadData;
  word_t pc;
  word_t pcPlus4;
  word_t readData1;
  word_t readData2;
  word_t operandB;
  word_t aluOut;
  word_t writeData;
  logic  commit;
  logic  zero;
  logic  regWriteEn;

  memRequest request0 (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .busy        (busy),
    .halt        (ctrl.isHalt),
    .pc          (pc),
    .dataAddr    (aluOut),     // rs1 plus offset.
    .storeData   (readData2),
    .ramLoad     (ramLoad),
    .memRead     (ctrl.memRead),
    .memWrite    (ctrl.memWrite),
    .ramAddr     (ramAddr),
    .ramStore    (ramStore),
    .ren         (ren),
    .wen         (wen),
    .halted      (halted),
    .instruction (instruction),
    .loadData    (loadData),
    .commit      (commit)
  );

  controlDecoder decoder0 (
    .instruction (instruction),
    .ctrl        (ctrl)
  );

  assign regWriteEn = commit & ctrl.regWrite;

  registerFile regFile0 (
    .clk       (clk),
    .reset     (reset),
    .writeEn   (regWriteEn),
    .readIdx1  (ctrl.rs1),
    .readIdx2  (ctrl.rs2),
    .writeIdx  (ctrl.rd),
    .writeData (writeData),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  assign operandB = ctrl.aluSrc ? ctrl.imm : readData2;

  aluUnit alu0 (
    .aluOp    (ctrl.aluOp),
    .inputA   (readData1),
    .inputB   (operandB),
    .result   (aluOut),
    .zero     (zero),
    .negative ()               // No branch in this subset tests the sign.
  );

  programCounter pc0 (
    .clk     (clk),
    .reset   (reset),
    .commit  (commit),
    .ctrl    (ctrl),
    .zero    (zero),
    .pc      (pc),
    .pcPlus4 (pcPlus4)
  );

  always_comb begin
    case (ctrl.wbSel)
      WB_MEM:  writeData = loadData;
      WB_PC4:  writeData = pcPlus4; // Link value before the PC moves.
      default: writeData = aluOut;
    endcase
  end

endmodule

// ==== tbRam.sv ====
// Simulation-only RAM of 256 words; address bits above 9 are ignored and each request waits 0 to 3 cycles.
module tbRam (
  input  logic          clk,
  input  logic          reset,
  input  logic          ren,
  input  logic          wen,
  input  cpuPkg::word_t ramAddr,
  input  cpuPkg::word_t ramStore,
  input  logic          loadEn,
  input  logic [7:0]    loadAddr,
  input  cpuPkg::word_t loadWord,
  output cpuPkg::word_t ramLoad,
  output logic          busy
);
  import cpuPkg::*;

  word_t      mem [256];  // Read by the testbench through the hierarchy.
  logic [1:0] waitCnt;    // Busy cycles left before the current request completes.
  logic [7:0] wordIdx;

  initial begin
    void'($urandom(32'h2626)); // One fixed seed for the whole run.
  end

  assign wordIdx = ramAddr[9:2];
  assign busy    = (ren || wen) && (waitCnt != 2'd0);
  assign ramLoad = mem[wordIdx]; // Valid in the same cycle as the address.

  always @(posedge clk) begin
    if (reset) begin
      waitCnt <= 2'($urandom % 4);
    end else if (ren || wen) begin
      if (waitCnt != 2'd0) begin
        waitCnt <= waitCnt - 2'd1;
      end else begin
        if (wen) begin
          mem[wordIdx] <= ramStore; // Write lands on the completing cycle.
        end
        waitCnt <= 2'($urandom % 4); // Delay drawn for the next request.
      end
    end
    if (loadEn) begin
      mem[loadAddr] <= loadWord;
    end
  end

endmodule

// ==== cpuTop_chk.sv ====
// Watches only the RAM port pins of cpuTop; the transfer checks are off while reset is high.
module cpuTop_chk (
  input logic          clk,
  input logic          reset,
  input logic          busy,
  input logic          ren,
  input logic          wen,
  input logic          halted,
  input cpuPkg::word_t ramAddr,
  input cpuPkg::word_t ramStore
);

  int failCount = 0; // Read by the testbench at the end of the run.

  oneAccessAtATime: assert property (@(posedge clk) disable iff (reset) !(ren && wen))
    else begin
      failCount++;
      $error("ren and wen are high in the same cycle");
    end

  holdWhileBusy: assert property (@(posedge clk) disable iff (reset)
      busy |=> ($stable(ramAddr) && $stable(ren) && $stable(wen) && $stable(ramStore)))
    else begin
      failCount++;
      $error("RAM request changed while busy was high");
    end

  quietAfterReset: assert property (@(posedge clk) reset |=> (!ren && !wen))
    else begin
      failCount++;
      $error("RAM request right after reset");
    end

  quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
      halted |-> (!ren && !wen))
    else begin
      failCount++;
      $error("RAM request while halted");
    end

endmodule

// ==== tb_cpuTop.sv ====
// Programs are hand-assembled RV32I words placed from address 0; results go to 0x200 upward.
module tb_cpuTop;
  import cpuPkg::*;

  localparam int TIMEOUT_CYCLES = 4000; // About 60 instructions with slow transfers and margin.
  localparam int DATA_BASE      = 'h200;
  localparam int OPERAND_A      = -7;
  localparam int OPERAND_B      = 12;
  localparam int LUI_UPPER      = 'h12345;
  localparam int LUI_LOWER      = 'h678;
  localparam int LOOP_COUNT     = 5;
  localparam int PRESET_0       = 'h1234;
  localparam int PRESET_1       = -16;

  logic       clk;
  logic       reset;
  logic       enable;
  logic       busy;
  logic       ren;
  logic       wen;
  logic       halted;
  logic       loadEn;
  logic [7:0] loadAddr;
  logic [7:0] emitIdx;
  word_t      loadWord;
  word_t      ramLoad;
  word_t      ramAddr;
  word_t      ramStore;
  word_t      image [256]; // RAM contents for the next test.

  cpuTop dut0 (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .ramLoad  (ramLoad),
    .busy     (busy),
    .ramAddr  (ramAddr),
    .ramStore (ramStore),
    .ren      (ren),
    .wen      (wen),
    .halted   (halted)
  );

  tbRam ram0 (
    .clk      (clk),
    .reset    (reset),
    .ren      (ren),
    .wen      (wen),
    .ramAddr  (ramAddr),
    .ramStore (ramStore),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadWord (loadWord),
    .ramLoad  (ramLoad),
    .busy     (busy)
  );

  bind cpuTop cpuTop_chk chk0 (
    .clk      (clk),
    .reset    (reset),
    .busy     (busy),
    .ren      (ren),
    .wen      (wen),
    .halted   (halted),
    .ramAddr  (ramAddr),
    .ramStore (ramStore)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic word_t rType(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t addi(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic word_t lw(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic word_t sw(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t branch(logic [2:0] f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t lui(int rd, int upper);
    return {upper[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic word_t jal(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic clearImage;
    for (int i = 0; i < 256; i++) begin
      image[8'(i)] = 32'hC0DE_0000 | (i * 4); // Fill marks each byte address.
    end
    emitIdx = 8'd0;
  endtask

  task automatic emit(input word_t instr);
    image[emitIdx] = instr;
    emitIdx = emitIdx + 8'd1;
  endtask

  task automatic checkValue(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("[ERROR] time %0t: %s expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic checkMem(input int byteAddr, input word_t expected);
    checkValue($sformatf("mem[0x%03h]", byteAddr), ram0.mem[8'(byteAddr / 4)], expected);
  endtask

  // Core is reset for 10 cycles and then waits in IDLE while the image is copied.
  task automatic loadAndStart;
    @(posedge clk);
    reset  <= 1'b1;
    enable <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      @(posedge clk);
      loadEn   <= 1'b1;
      loadAddr <= 8'(i);
      loadWord <= image[8'(i)];
    end
    @(posedge clk);
    loadEn <= 1'b0;
    enable <= 1'b1;
  endtask

  task automatic waitHalted;
    int cycles;
    cycles = 0;
    while (!halted) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: the core did not halt within %0d cycles.", TIMEOUT_CYCLES);
        $display("Test failed");
        $fatal(1, "timeout");
      end
    end
  endtask

  task automatic buildArith;
    clearImage();
    emit(addi(1, 0, OPERAND_A));
    emit(addi(2, 0, OPERAND_B));
    emit(rType(7'b0000000, 3'b000, 3, 1, 2)); // ADD.
    emit(rType(7'b0100000, 3'b000, 4, 1, 2)); // SUB.
    emit(rType(7'b0000000, 3'b111, 5, 1, 2)); // AND.
    emit(rType(7'b0000000, 3'b110, 6, 1, 2)); // OR.
    emit(rType(7'b0000000, 3'b100, 7, 1, 2)); // XOR.
    emit(rType(7'b0000000, 3'b010, 8, 1, 2)); // SLT with the negative operand on the left.
    emit(rType(7'b0000000, 3'b010, 9, 2, 1));
    emit(lui(10, LUI_UPPER));
    emit(addi(11, 10, LUI_LOWER));
    for (int k = 0; k < 9; k++) begin
      emit(sw(3 + k, 0, DATA_BASE + 4 * k));
    end
    emit(32'h0010_0073);                      // EBREAK.
  endtask

  task automatic checkArith;
    checkMem(DATA_BASE, OPERAND_A + OPERAND_B);
    checkMem(DATA_BASE + 4, OPERAND_A - OPERAND_B);
    checkMem(DATA_BASE + 8, OPERAND_A & OPERAND_B);
    checkMem(DATA_BASE + 12, OPERAND_A | OPERAND_B);
    checkMem(DATA_BASE + 16, OPERAND_A ^ OPERAND_B);
    checkMem(DATA_BASE + 20, (OPERAND_A < OPERAND_B) ? 1 : 0);
    checkMem(DATA_BASE + 24, (OPERAND_B < OPERAND_A) ? 1 : 0);
    checkMem(DATA_BASE + 28, LUI_UPPER << 12);
    checkMem(DATA_BASE + 32, (LUI_UPPER << 12) + LUI_LOWER);
  endtask

  task automatic arithAndLogic;
    buildArith();
    loadAndStart();
    waitHalted();
    checkArith();
  endtask

  task automatic loadAndStore;
    clearImage();
    image[8'('h280 / 4)] = PRESET_0;
    image[8'('h284 / 4)] = PRESET_1;
    emit(addi(1, 0, 'h284));
    emit(lw(2, 1, -4));
    emit(lw(3, 1, 0));
    emit(rType(7'b0000000, 3'b000, 4, 2, 3));
    emit(addi(5, 3, 100));
    emit(sw(4, 1, 12));
    emit(sw(5, 1, -8));
    emit(sw(2, 1, 16));
    emit(32'h0010_0073);
    loadAndStart();
    waitHalted();
    checkMem('h290, PRESET_0 + PRESET_1);
    checkMem('h27C, PRESET_1 + 100);
    checkMem('h294, PRESET_0);
  endtask

  task automatic branchesAndJump;
    word_t jalAddr;
    clearImage();
    emit(addi(1, 0, LOOP_COUNT));
    emit(addi(2, 0, 0));
    emit(addi(2, 2, 1));                      // Loop body at 0x8.
    emit(addi(1, 1, -1));
    emit(branch(3'b001, 1, 0, -8));           // BNE back to the loop body.
    emit(branch(3'b000, 2, 2, 8));            // BEQ over the next word.
    emit(addi(2, 0, 99));
    jalAddr = 32'(emitIdx) * 4;
    emit(jal(3, 8));
    emit(addi(2, 0, 77));
    emit(sw(2, 0, DATA_BASE));
    emit(sw(3, 0, DATA_BASE + 4));
    emit(sw(1, 0, DATA_BASE + 8));
    emit(32'h0010_0073);
    loadAndStart();
    waitHalted();
    checkMem(DATA_BASE, LOOP_COUNT);
    checkMem(DATA_BASE + 4, jalAddr + 4);
    checkMem(DATA_BASE + 8, 0);
  endtask

  task automatic zeroRegAndHalt;
    clearImage();
    emit(addi(0, 0, 123));
    emit(addi(1, 0, 55));
    emit(rType(7'b0000000, 3'b000, 0, 1, 1));
    emit(sw(0, 0, DATA_BASE));
    emit(sw(1, 0, DATA_BASE + 4));
    emit(32'h0010_0073);
    loadAndStart();
    waitHalted();
    checkMem(DATA_BASE, 0);
    checkMem(DATA_BASE + 4, 55);
    repeat (20) begin
      @(negedge clk);
      checkValue("halted", 32'(halted), 1);
      checkValue("ren", 32'(ren), 0);
      checkValue("wen", 32'(wen), 0);
    end
  endtask

  // The pause starts mid-program; the in-flight instruction ends within 20 cycles.
  task automatic enablePause;
    buildArith();
    loadAndStart();
    repeat (30) @(posedge clk);
    enable <= 1'b0;
    repeat (20) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      checkValue("halted", 32'(halted), 0);
      checkValue("ren", 32'(ren), 0);
      checkValue("wen", 32'(wen), 0);
    end
    @(posedge clk);
    enable <= 1'b1;
    waitHalted();
    checkArith();
  endtask

  initial begin
    reset    = 1'b1;
    enable   = 1'b0;
    loadEn   = 1'b0;
    loadAddr = 8'd0;
    loadWord = '0;
    emitIdx  = 8'd0;
    arithAndLogic();
    loadAndStore();
    branchesAndJump();
    zeroRegAndHalt();
    enablePause();
    if (dut0.chk0.failCount != 0) begin
      $display("Port protocol assertions failed %0d times.", dut0.chk0.failCount);
      $display("Test failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// ==== all.f ====
cpuPkg.sv
controlDecoder.sv
aluUnit.sv
registerFile.sv
programCounter.sv
memRequest.sv
cpuTop.sv
tbRam.sv
cpuTop_chk.sv
tb_cpuTop.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_cpuTop
FILELIST := all.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'Test passed' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
